//--- design/fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl import fetch_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 init_i,
    input  logic [ADDR_BITS-1:0] init_addr_i,
    input  logic                 resteer_i,
    input  logic [ADDR_BITS-1:0] wb_fip_i,
    input  logic                 br_taken_i,
    input  logic [ADDR_BITS-1:0] bp_target_i,
    input  logic [NUM_SLOTS-1:0] slot_valid_i,
    input  fetch_addr_u          next_addr_i,
    input  logic                 mem_rdy_i,
    input  logic [LINE_BITS-1:0] mem_line_i,
    output redirect_t            redirect_o,
    output logic                 advance_o,
    output logic                 mem_req_o,
    output logic [ADDR_BITS-1:0] mem_addr_o,
    output line_fill_t           fill_o
);

    fetch_state_e state_q;
    fetch_state_e state_d;
    logic [1:0]   req_slot_q;

    //////////////////////////////////////////////////////////////////////
    // redirect priority: init, then resteer, then taken branch
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        redirect_o = '0;
        if (init_i) begin
            redirect_o.valid       = 1'b1;
            redirect_o.target.flat = init_addr_i;
        end else if (resteer_i) begin
            redirect_o.valid       = 1'b1;
            redirect_o.target.flat = wb_fip_i;
        end else if (br_taken_i) begin
            redirect_o.valid       = 1'b1;
            redirect_o.target.flat = bp_target_i;
        end
    end

    // only one line in flight, and only into a free slot
    assign mem_req_o  = (state_q == REQ) && !slot_valid_i[next_addr_i.f.slot]
                        && !redirect_o.valid;
    assign mem_addr_o = next_addr_i.flat;
    assign advance_o  = mem_req_o;

    // a return that races a redirect is thrown away
    assign fill_o.valid = (state_q == WAIT) && mem_rdy_i && !redirect_o.valid;
    assign fill_o.slot  = req_slot_q;
    assign fill_o.line  = mem_line_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (redirect_o.valid) begin
                    state_d = REQ;
                end
            end
            REQ: begin
                if (mem_req_o) begin
                    state_d = WAIT;
                end
            end
            WAIT: begin
                if (mem_rdy_i) begin
                    state_d = REQ;
                end else if (redirect_o.valid) begin
                    state_d = DROP;
                end
            end
            DROP: begin
                // stale line arrives, refetch from the new pointer
                if (mem_rdy_i) begin
                    state_d = REQ;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // slot that the outstanding line belongs to
    always_ff @(posedge clk) begin
        if (mem_req_o) begin
            req_slot_q <= next_addr_i.f.slot;
        end
    end

endmodule

//--- design/fetch_pkg.sv
package fetch_pkg;

    //////////////////////////////////////////////////////////////////////
    // line and buffer geometry
    //////////////////////////////////////////////////////////////////////

    localparam int LINE_BYTES = 16;
    localparam int LINE_BITS  = 128;
    localparam int NUM_SLOTS  = 4;
    localparam int ADDR_BITS  = 32;

    //////////////////////////////////////////////////////////////////////
    // fetch address, flat or split into line fields
    //////////////////////////////////////////////////////////////////////

    typedef union packed {
        logic [ADDR_BITS-1:0] flat;
        struct packed {
            logic [ADDR_BITS-7:0] tag;
            // low line bits pick the buffer slot
            logic [1:0]           slot;
            logic [3:0]           offset;
        } f;
    } fetch_addr_u;

    // one redirect command, already resolved by priority
    typedef struct packed {
        logic        valid;
        fetch_addr_u target;
    } redirect_t;

    // write port into the line buffer
    typedef struct packed {
        logic                 valid;
        logic [1:0]           slot;
        logic [LINE_BITS-1:0] line;
    } line_fill_t;

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT,
        DROP
    } fetch_state_e;

endpackage

//--- design/fetch_ptr.sv
`timescale 1ns/1ps

module fetch_ptr import fetch_pkg::*; (
    input  logic        clk,
    input  logic        rst_n_i,
    input  redirect_t   redirect_i,
    input  logic        advance_i,
    output fetch_addr_u next_addr_o
);

    // mask for the byte offset within a line
    localparam logic [ADDR_BITS-1:0] OFFSET_MASK = ADDR_BITS'(LINE_BYTES - 1);

    fetch_addr_u addr_q;
    fetch_addr_u addr_d;

    //////////////////////////////////////////////////////////////////////
    // next line to request
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        addr_d = addr_q;
        if (redirect_i.valid) begin
            // start at the line holding the target byte
            addr_d.flat = redirect_i.target.flat & ~OFFSET_MASK;
        end else if (advance_i) begin
            addr_d.flat = addr_q.flat + ADDR_BITS'(LINE_BYTES);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            addr_q <= '0;
        end else begin
            addr_q <= addr_d;
        end
    end

    assign next_addr_o = addr_q;

endmodule

//--- design/fetch_top.sv
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n_i,

    // redirect sources
    input  logic                 init_i,
    input  logic [ADDR_BITS-1:0] init_addr_i,
    input  logic                 resteer_i,
    input  logic [ADDR_BITS-1:0] wb_fip_i,
    input  logic                 br_taken_i,
    input  logic [ADDR_BITS-1:0] bp_target_i,

    // line memory
    output logic                 mem_req_o,
    output logic [ADDR_BITS-1:0] mem_addr_o,
    input  logic                 mem_rdy_i,
    input  logic [LINE_BITS-1:0] mem_line_i,

    // decode
    input  logic                 stall_i,
    input  logic [3:0]           length_i,
    input  logic                 idt_sel_i,
    input  logic [LINE_BITS-1:0] idt_packet_i,
    output logic [LINE_BITS-1:0] packet_o,
    output logic                 packet_valid_o
);

    redirect_t                           redirect;
    logic                                advance;
    fetch_addr_u                         next_addr;
    line_fill_t                          fill;
    logic [NUM_SLOTS-1:0][LINE_BITS-1:0] lines;
    logic [NUM_SLOTS-1:0]                slot_valid;
    logic                                retire;
    logic [1:0]                          retire_slot;

    //////////////////////////////////////////////////////////////////////
    // request side
    //////////////////////////////////////////////////////////////////////

    fetch_ctrl u_ctrl (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .init_i       (init_i),
        .init_addr_i  (init_addr_i),
        .resteer_i    (resteer_i),
        .wb_fip_i     (wb_fip_i),
        .br_taken_i   (br_taken_i),
        .bp_target_i  (bp_target_i),
        .slot_valid_i (slot_valid),
        .next_addr_i  (next_addr),
        .mem_rdy_i    (mem_rdy_i),
        .mem_line_i   (mem_line_i),
        .redirect_o   (redirect),
        .advance_o    (advance),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .fill_o       (fill)
    );

    fetch_ptr u_ptr (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .redirect_i  (redirect),
        .advance_i   (advance),
        .next_addr_o (next_addr)
    );

    //////////////////////////////////////////////////////////////////////
    // buffer and decode side
    //////////////////////////////////////////////////////////////////////

    ibuf_lines u_lines (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .redirect_i    (redirect),
        .fill_i        (fill),
        .retire_i      (retire),
        .retire_slot_i (retire_slot),
        .lines_o       (lines),
        .slot_valid_o  (slot_valid)
    );

    packet_align u_align (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .redirect_i     (redirect),
        .lines_i        (lines),
        .slot_valid_i   (slot_valid),
        .stall_i        (stall_i),
        .length_i       (length_i),
        .idt_sel_i      (idt_sel_i),
        .idt_packet_i   (idt_packet_i),
        .packet_o       (packet_o),
        .packet_valid_o (packet_valid_o),
        .retire_o       (retire),
        .retire_slot_o  (retire_slot)
    );

endmodule

//--- design/ibuf_lines.sv
`timescale 1ns/1ps

module ibuf_lines import fetch_pkg::*; (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  redirect_t                           redirect_i,
    input  line_fill_t                          fill_i,
    input  logic                                retire_i,
    input  logic [1:0]                          retire_slot_i,
    output logic [NUM_SLOTS-1:0][LINE_BITS-1:0] lines_o,
    output logic [NUM_SLOTS-1:0]                slot_valid_o
);

    logic [NUM_SLOTS-1:0][LINE_BITS-1:0] lines_q;
    logic [NUM_SLOTS-1:0]                valid_q;
    logic [NUM_SLOTS-1:0]                valid_d;

    //////////////////////////////////////////////////////////////////////
    // line storage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (fill_i.valid) begin
            lines_q[fill_i.slot] <= fill_i.line;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // valid bits
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        valid_d = valid_q;
        if (redirect_i.valid) begin
            // flush on every redirect
            valid_d = '0;
        end else begin
            if (retire_i) begin
                valid_d[retire_slot_i] = 1'b0;
            end
            // fill after retire so a same-slot fill wins
            if (fill_i.valid) begin
                valid_d[fill_i.slot] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_d;
        end
    end

    assign lines_o      = lines_q;
    assign slot_valid_o = valid_q;

endmodule

//--- design/packet_align.sv
`timescale 1ns/1ps

module packet_align import fetch_pkg::*; (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  redirect_t                           redirect_i,
    input  logic [NUM_SLOTS-1:0][LINE_BITS-1:0] lines_i,
    input  logic [NUM_SLOTS-1:0]                slot_valid_i,
    input  logic                                stall_i,
    input  logic [3:0]                          length_i,
    input  logic                                idt_sel_i,
    input  logic [LINE_BITS-1:0]                idt_packet_i,
    output logic [LINE_BITS-1:0]                packet_o,
    output logic                                packet_valid_o,
    output logic                                retire_o,
    output logic [1:0]                          retire_slot_o
);

    fetch_addr_u            ptr_q;
    logic [1:0]             cur_slot;
    logic [1:0]             nxt_slot;
    logic [2*LINE_BITS-1:0] line_pair;
    logic [2*LINE_BITS-1:0] pair_shifted;
    logic                   lines_ready;
    logic                   consume;
    logic [4:0]             off_sum;

    //////////////////////////////////////////////////////////////////////
    // packet assembly across two lines
    //////////////////////////////////////////////////////////////////////

    assign cur_slot = ptr_q.f.slot;
    // wraps from slot 3 back to slot 0
    assign nxt_slot = ptr_q.f.slot + 2'd1;

    assign lines_ready = slot_valid_i[cur_slot] && slot_valid_i[nxt_slot];

    // byte 0 of a line sits in the low bits
    assign line_pair    = {lines_i[nxt_slot], lines_i[cur_slot]};
    assign pair_shifted = line_pair >> {ptr_q.f.offset, 3'b000};

    // descriptor packet overrides fetched bytes and is always valid
    assign packet_o       = idt_sel_i ? idt_packet_i : pair_shifted[LINE_BITS-1:0];
    assign packet_valid_o = idt_sel_i || lines_ready;

    //////////////////////////////////////////////////////////////////////
    // consumption and retire
    //////////////////////////////////////////////////////////////////////

    assign consume = lines_ready && !stall_i && !idt_sel_i && !redirect_i.valid;

    // carry out of the offset means the current line is used up
    assign off_sum       = {1'b0, ptr_q.f.offset} + {1'b0, length_i};
    assign retire_o      = consume && off_sum[4];
    assign retire_slot_o = cur_slot;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ptr_q <= '0;
        end else if (redirect_i.valid) begin
            ptr_q <= redirect_i.target;
        end else if (consume) begin
            ptr_q.flat <= ptr_q.flat + ADDR_BITS'(length_i);
        end
    end

endmodule

//--- dv/fetch_props.sv
`timescale 1ns/1ps

module fetch_props import fetch_pkg::*; (
    input logic                 clk,
    input logic                 rst_n_i,
    input logic                 init_i,
    input logic [ADDR_BITS-1:0] init_addr_i,
    input logic                 resteer_i,
    input logic [ADDR_BITS-1:0] wb_fip_i,
    input logic                 br_taken_i,
    input logic [ADDR_BITS-1:0] bp_target_i,
    input logic                 mem_req_i,
    input logic [ADDR_BITS-1:0] mem_addr_i,
    input logic                 mem_rdy_i,
    input logic                 stall_i,
    input logic [3:0]           length_i,
    input logic                 idt_sel_i,
    input logic [LINE_BITS-1:0] idt_packet_i,
    input logic [LINE_BITS-1:0] packet_i,
    input logic                 packet_valid_i,
    input logic [ADDR_BITS-1:0] ptr_i
);

    int unsigned          fail_cnt = 0;
    logic                 redir;
    logic [ADDR_BITS-1:0] redir_tgt;
    logic [ADDR_BITS-1:0] exp_ptr;
    logic                 seen_redir;
    logic                 outstanding;
    logic [ADDR_BITS-5:0] req_ahead;

    // bytes expected at addr, addr+1, ... from the memory pattern
    function automatic logic [LINE_BITS-1:0] pattern_at(input logic [ADDR_BITS-1:0] addr);
        logic [LINE_BITS-1:0] v;
        logic [ADDR_BITS-1:0] a;
        for (int i = 0; i < LINE_BYTES; i++) begin
            a = addr + ADDR_BITS'(i);
            v[i*8 +: 8] = a[7:0] ^ 8'h5a;
        end
        return v;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // reference pointer model
    //////////////////////////////////////////////////////////////////////

    assign redir     = init_i || resteer_i || br_taken_i;
    assign redir_tgt = init_i ? init_addr_i : (resteer_i ? wb_fip_i : bp_target_i);

    // lines the request runs ahead of the pointer's line
    assign req_ahead = mem_addr_i[ADDR_BITS-1:4] - exp_ptr[ADDR_BITS-1:4];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            exp_ptr     <= '0;
            seen_redir  <= 1'b0;
            outstanding <= 1'b0;
        end else begin
            if (redir) begin
                exp_ptr    <= redir_tgt;
                seen_redir <= 1'b1;
            end else if (packet_valid_i && !stall_i && !idt_sel_i) begin
                exp_ptr <= exp_ptr + ADDR_BITS'(length_i);
            end
            // one line in flight from request to ready
            if (mem_req_i) begin
                outstanding <= 1'b1;
            end else if (mem_rdy_i) begin
                outstanding <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    a_quiet: assert property (@(posedge clk) disable iff (!rst_n_i)
        !seen_redir |-> !mem_req_i && !packet_valid_i)
        else begin
            fail_cnt++;
            $error("Error at %0t: activity before the first redirect", $time);
        end

    a_one_outstanding: assert property (@(posedge clk) disable iff (!rst_n_i)
        outstanding |-> !mem_req_i)
        else begin
            fail_cnt++;
            $error("Error at %0t: request while a line is outstanding", $time);
        end

    // a request is line aligned and stays within the four buffered lines
    a_req_window: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_req_i |-> mem_addr_i[3:0] == 4'h0 && req_ahead < NUM_SLOTS)
        else begin
            fail_cnt++;
            $error("Error at %0t: request address %h, pointer %h", $time, mem_addr_i, exp_ptr);
        end

    a_ptr_track: assert property (@(posedge clk) disable iff (!rst_n_i)
        ptr_i == exp_ptr)
        else begin
            fail_cnt++;
            $error("Error at %0t: pointer %h, expected %h", $time, ptr_i, exp_ptr);
        end

    a_packet_bytes: assert property (@(posedge clk) disable iff (!rst_n_i)
        packet_valid_i && !idt_sel_i |-> packet_i == pattern_at(exp_ptr))
        else begin
            fail_cnt++;
            $error("Error at %0t: packet %h wrong for pointer %h", $time, packet_i, exp_ptr);
        end

    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_i && packet_valid_i && !idt_sel_i && !redir
        |=> idt_sel_i || packet_i == $past(packet_i))
        else begin
            fail_cnt++;
            $error("Error at %0t: packet changed during stall", $time);
        end

    a_ptr_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        (stall_i || idt_sel_i) && !redir |=> ptr_i == $past(ptr_i))
        else begin
            fail_cnt++;
            $error("Error at %0t: pointer moved during stall or descriptor", $time);
        end

    a_idt_packet: assert property (@(posedge clk) disable iff (!rst_n_i)
        idt_sel_i |-> packet_valid_i && packet_i == idt_packet_i)
        else begin
            fail_cnt++;
            $error("Error at %0t: descriptor packet not presented", $time);
        end

endmodule

bind fetch_top fetch_props u_props (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .init_i         (init_i),
    .init_addr_i    (init_addr_i),
    .resteer_i      (resteer_i),
    .wb_fip_i       (wb_fip_i),
    .br_taken_i     (br_taken_i),
    .bp_target_i    (bp_target_i),
    .mem_req_i      (mem_req_o),
    .mem_addr_i     (mem_addr_o),
    .mem_rdy_i      (mem_rdy_i),
    .stall_i        (stall_i),
    .length_i       (length_i),
    .idt_sel_i      (idt_sel_i),
    .idt_packet_i   (idt_packet_i),
    .packet_i       (packet_o),
    .packet_valid_i (packet_valid_o),
    .ptr_i          (u_align.ptr_q)
);

//--- dv/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb import fetch_pkg::*; ();

    localparam int NUM_TESTS  = 5;
    localparam int SEQ_LEN    = 400;
    // four times the cycles that all tests together can take
    localparam int MAX_CYCLES = 4 * NUM_TESTS * SEQ_LEN;

    logic                 clk = 1'b0;
    logic                 rst_n;
    logic                 init;
    logic [ADDR_BITS-1:0] init_addr;
    logic                 resteer;
    logic [ADDR_BITS-1:0] wb_fip;
    logic                 br_taken;
    logic [ADDR_BITS-1:0] bp_target;
    logic                 mem_req;
    logic [ADDR_BITS-1:0] mem_addr;
    logic                 mem_rdy;
    logic [LINE_BITS-1:0] mem_line;
    logic                 stall;
    logic [3:0]           length;
    logic                 idt_sel;
    logic [LINE_BITS-1:0] idt_packet;
    logic [LINE_BITS-1:0] packet;
    logic                 packet_valid;

    logic [31:0]          lfsr_q = 32'hc691_8793;
    int                   cycles = 0;
    int                   tests_failed = 0;
    int                   err_before = 0;

    // line memory model
    logic                 req_seen = 1'b0;
    logic [ADDR_BITS-1:0] req_addr;
    logic                 mem_busy = 1'b0;
    int                   mem_wait = 0;
    logic [ADDR_BITS-1:0] pend_addr;

    always #2 clk = ~clk;

    fetch_top uut (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .init_i         (init),
        .init_addr_i    (init_addr),
        .resteer_i      (resteer),
        .wb_fip_i       (wb_fip),
        .br_taken_i     (br_taken),
        .bp_target_i    (bp_target),
        .mem_req_o      (mem_req),
        .mem_addr_o     (mem_addr),
        .mem_rdy_i      (mem_rdy),
        .mem_line_i     (mem_line),
        .stall_i        (stall),
        .length_i       (length),
        .idt_sel_i      (idt_sel),
        .idt_packet_i   (idt_packet),
        .packet_o       (packet),
        .packet_valid_o (packet_valid)
    );

    //////////////////////////////////////////////////////////////////////
    // random source and memory
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
        return v;
    endfunction

    // every byte is its address low byte xor 5a
    function automatic logic [LINE_BITS-1:0] line_at(input logic [ADDR_BITS-1:0] addr);
        logic [LINE_BITS-1:0] v;
        logic [ADDR_BITS-1:0] a;
        for (int i = 0; i < LINE_BYTES; i++) begin
            a = addr + ADDR_BITS'(i);
            v[i*8 +: 8] = a[7:0] ^ 8'h5a;
        end
        return v;
    endfunction

    // request as the DUT saw it at the edge
    always @(posedge clk) begin
        if (mem_req) begin
            req_seen <= 1'b1;
            req_addr <= mem_addr;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout, the run went past %0d cycles", MAX_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    // memory answers on a falling edge 1 to 4 cycles after the request
    task automatic next_cycle();
        @(negedge clk);
        if (req_seen) begin
            req_seen  = 1'b0;
            mem_busy  = 1'b1;
            mem_wait  = int'(take_bits(2)) + 1;
            pend_addr = req_addr;
        end
        mem_rdy = 1'b0;
        if (mem_busy) begin
            mem_wait--;
            if (mem_wait == 0) begin
                mem_rdy  = 1'b1;
                mem_line = line_at(pend_addr);
                mem_busy = 1'b0;
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic run_traffic(input int n, input bit use_stall, input bit use_redir,
                               input bit use_idt);
        logic [31:0] r;
        logic [2:0]  pick;
        repeat (n) begin
            next_cycle();
            r = take_bits(4);
            length = (r[3:0] == 4'd0) ? 4'd15 : r[3:0];
            stall = 1'b0;
            if (use_stall) begin
                r = take_bits(1);
                stall = r[0];
            end
            {init, resteer, br_taken} = 3'b000;
            if (use_redir && take_bits(5) == 0) begin
                // any mix of the three exercises the priority
                r = take_bits(3);
                pick = r[2:0];
                {init, resteer, br_taken} = (pick == 3'b000) ? 3'b001 : pick;
                init_addr = take_bits(32);
                wb_fip    = take_bits(32);
                bp_target = take_bits(32);
            end
            idt_sel = use_idt && (take_bits(2) == 0);
            if (idt_sel) begin
                for (int k = 0; k < 4; k++) begin
                    idt_packet[k*32 +: 32] = take_bits(32);
                end
            end
        end
    endtask

    task automatic send_init(input logic [ADDR_BITS-1:0] addr);
        next_cycle();
        init      = 1'b1;
        init_addr = addr;
        stall     = 1'b0;
        idt_sel   = 1'b0;
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = int'(uut.u_props.fail_cnt) - err_before;
        if (errs == 0) begin
            $display("test %s: pass", name);
        end else begin
            $display("test %s: FAIL with %0d assertion errors", name, errs);
            tests_failed++;
        end
        err_before = int'(uut.u_props.fail_cnt);
    endtask

    initial begin
        rst_n      = 1'b0;
        {init, resteer, br_taken} = 3'b000;
        init_addr  = '0;
        wb_fip     = '0;
        bp_target  = '0;
        mem_rdy    = 1'b0;
        mem_line   = '0;
        stall      = 1'b0;
        length     = 4'd1;
        idt_sel    = 1'b0;
        idt_packet = '0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        run_traffic(20, 1'b0, 1'b0, 1'b0);
        finish_test("reset_quiet");
        send_init(take_bits(32));
        run_traffic(SEQ_LEN, 1'b0, 1'b0, 1'b0);
        finish_test("sequential");
        run_traffic(SEQ_LEN, 1'b1, 1'b0, 1'b0);
        finish_test("stall");
        run_traffic(SEQ_LEN, 1'b1, 1'b1, 1'b0);
        finish_test("redirect");
        run_traffic(SEQ_LEN, 1'b1, 1'b0, 1'b1);
        finish_test("idt_select");

        // let the last cycles reach the checks
        repeat (2) next_cycle();
        $display("tests run %0d, tests failed %0d, assertion errors %0d",
                 NUM_TESTS, tests_failed, uut.u_props.fail_cnt);
        if (tests_failed == 0 && uut.u_props.fail_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- files.f
design/fetch_pkg.sv
design/fetch_ctrl.sv
design/fetch_ptr.sv
design/ibuf_lines.sv
design/packet_align.sv
design/fetch_top.sv
dv/fetch_props.sv
dv/fetch_tb.sv
